// ==== design/fetch_pkg.sv ====
package fetch_pkg;

    // ---------------------------------------------------
    // word and field widths
    // ---------------------------------------------------
    parameter int NB_INSTRUCTION = 32;
    parameter int NB_BYTE        = 8;
    parameter int NB_OPCODE      = 6;

    // opcodes resolved inside the fetch unit
    localparam logic [NB_OPCODE-1:0] OP_JUMP      = 6'd2;
    localparam logic [NB_OPCODE-1:0] OP_BRANCH_EQ = 6'd4;
    localparam logic [NB_OPCODE-1:0] OP_HALT      = 6'h3f;

    // ---------------------------------------------------
    // instruction formats
    // ---------------------------------------------------
    // i-type, immediate is a signed word offset
    typedef struct packed {
        logic [NB_OPCODE-1:0] opcode;
        logic [4:0]           rs;
        logic [4:0]           rt;
        logic [15:0]          immediate;
    } i_format_t;

    // j-type, target is a word address
    typedef struct packed {
        logic [NB_OPCODE-1:0] opcode;
        logic [25:0]          target;
    } j_format_t;

    // same 32 bits, two decodings
    typedef union packed {
        i_format_t i_view;
        j_format_t j_view;
    } instruction_t;

endpackage

// ==== design/instruction_memory.sv ====
`timescale 1ns/1ps

module instruction_memory
#(
    parameter int N_INSTRUCTIONS = 64,
    parameter int NB_ADDRESS     = 8
)
(
    input  logic                                i_clock,
    input  logic                                i_reset,
    input  logic                                i_write_enable,
    input  logic [fetch_pkg::NB_BYTE-1:0]       i_write_data,
    input  logic [NB_ADDRESS-1:0]               i_read_address,
    output logic [fetch_pkg::NB_INSTRUCTION-1:0] o_read_instruction,
    output logic                                o_is_program_end
);
    import fetch_pkg::*;

    localparam int N_BYTES = N_INSTRUCTIONS * 4;

    // highest word-aligned address
    localparam logic [NB_ADDRESS-1:0] LAST_WORD_ADDRESS = NB_ADDRESS'(N_BYTES - 4);

    logic [NB_BYTE-1:0]        memory_bytes [N_BYTES];
    logic [NB_ADDRESS-1:0]     write_pointer;
    logic [NB_INSTRUCTION-1:0] read_instruction;
    logic                      is_program_end;
    logic                      end_condition;

    // ---------------------------------------------------
    // write pointer
    // ---------------------------------------------------
    // counts loaded bytes, wraps at the memory size
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            write_pointer <= '0;
        end else if (i_write_enable) begin
            write_pointer <= write_pointer + NB_ADDRESS'(1);
        end
    end

    // byte store, cleared as a whole on reset
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < N_BYTES; i++) begin
                memory_bytes[i] <= '0;
            end
        end else if (i_write_enable) begin
            memory_bytes[write_pointer] <= i_write_data;
        end
    end

    // ---------------------------------------------------
    // word read on the falling edge
    // ---------------------------------------------------
    // past the loaded bytes, or sitting on the last word
    assign end_condition = (i_read_address >= write_pointer) ||
                           (i_read_address == LAST_WORD_ADDRESS);

    // big endian: lowest address is the top byte
    always_ff @(negedge i_clock) begin
        read_instruction <= {memory_bytes[i_read_address],
                             memory_bytes[i_read_address + NB_ADDRESS'(1)],
                             memory_bytes[i_read_address + NB_ADDRESS'(2)],
                             memory_bytes[i_read_address + NB_ADDRESS'(3)]};
        is_program_end   <= end_condition;
    end

    // both settle half a cycle before the next rising edge
    assign o_read_instruction = read_instruction;
    assign o_is_program_end   = is_program_end;

endmodule

// ==== design/fetch_control.sv ====
`timescale 1ns/1ps

module fetch_control
(
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_load_valid,
    input  logic i_mode_write,
    input  logic i_mode_step,
    input  logic i_start,
    input  logic i_step,
    input  logic i_stop,
    input  logic i_is_program_end,
    output logic o_write_enable,
    output logic o_restart,
    output logic o_advance,
    output logic o_running,
    output logic o_halted
);

    // state encoding
    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_RUNNING = 2'd1;
    localparam logic [1:0] ST_HALTED  = 2'd2;

    logic [1:0] state;
    logic [1:0] next_state;
    logic       is_running;
    logic       step_mode;
    logic       step_pending;
    logic       halted;

    assign is_running = (state == ST_RUNNING);

    // ---------------------------------------------------
    // run mode
    // ---------------------------------------------------
    // 0 continuous, 1 single step
    // only changed while nothing is fetching
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            step_mode <= 1'b0;
        end else if (i_mode_write && !is_running) begin
            step_mode <= i_mode_step;
        end
    end

    // step pulse held for its advance cycle
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            step_pending <= 1'b0;
        end else begin
            step_pending <= is_running && step_mode && i_step;
        end
    end

    // ---------------------------------------------------
    // run / halt fsm
    // ---------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            ST_RUNNING: if (i_stop)  next_state = ST_HALTED;
            default:    if (i_start) next_state = ST_RUNNING;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // halted flag trails the fsm by one cycle
    // so the last valid word never overlaps it
    always_ff @(posedge i_clock) begin
        if (i_reset || i_start) begin
            halted <= 1'b0;
        end else begin
            halted <= (state == ST_HALTED);
        end
    end

    // loads only land while stopped
    assign o_write_enable = i_load_valid && !is_running;
    // pc back to zero on the start edge
    assign o_restart      = i_start && !is_running;
    // step mode: no step needed to notice the end of the program
    assign o_advance      = is_running && (!step_mode || step_pending || i_is_program_end);
    assign o_running      = is_running;
    assign o_halted       = halted;

endmodule

// ==== design/program_counter.sv ====
`timescale 1ns/1ps

module program_counter
#(
    parameter int NB_ADDRESS = 8
)
(
    input  logic                                 i_clock,
    input  logic                                 i_reset,
    input  logic                                 i_restart,
    input  logic                                 i_advance,
    input  logic                                 i_is_program_end,
    input  logic [fetch_pkg::NB_INSTRUCTION-1:0] i_instruction,
    output logic [NB_ADDRESS-1:0]                o_read_address,
    output logic                                 o_stop,
    output logic [fetch_pkg::NB_INSTRUCTION-1:0] o_instruction,
    output logic [NB_ADDRESS-1:0]                o_instruction_pc,
    output logic                                 o_instruction_valid
);
    import fetch_pkg::*;

    instruction_t              instruction;
    logic [NB_ADDRESS-1:0]     pc;
    logic [NB_ADDRESS-1:0]     sequential_pc;
    logic [NB_ADDRESS-1:0]     next_pc;
    logic [NB_INSTRUCTION-1:0] jump_address;
    logic [NB_INSTRUCTION-1:0] branch_offset;
    logic                      is_jump;
    logic                      is_branch_taken;
    logic                      is_halt;
    logic                      fetch;

    assign instruction = i_instruction;

    // ---------------------------------------------------
    // decode of the word at pc
    // ---------------------------------------------------
    assign is_jump         = (instruction.i_view.opcode == OP_JUMP);
    // beq with equal register fields needs no register values
    assign is_branch_taken = (instruction.i_view.opcode == OP_BRANCH_EQ) &&
                             (instruction.i_view.rs == instruction.i_view.rt);
    assign is_halt         = (instruction.i_view.opcode == OP_HALT);

    // word target to byte address
    assign jump_address  = {4'b0000, instruction.j_view.target, 2'b00};
    // sign extended word offset, in bytes
    assign branch_offset = {{14{instruction.i_view.immediate[15]}},
                            instruction.i_view.immediate, 2'b00};

    assign sequential_pc = pc + NB_ADDRESS'(4);

    // jump wins over branch, both truncate to the memory
    always_comb begin
        if (is_jump) begin
            next_pc = jump_address[NB_ADDRESS-1:0];
        end else if (is_branch_taken) begin
            next_pc = sequential_pc + branch_offset[NB_ADDRESS-1:0];
        end else begin
            next_pc = sequential_pc;
        end
    end

    // end of program blocks the fetch, halt word still goes out
    assign fetch  = i_advance && !i_is_program_end;
    assign o_stop = i_advance && (i_is_program_end || is_halt);

    // ---------------------------------------------------
    // pc and output registers
    // ---------------------------------------------------
    always_ff @(posedge i_clock) begin
        if (i_reset || i_restart) begin
            pc <= '0;
        end else if (fetch) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_instruction_valid <= 1'b0;
        end else begin
            o_instruction_valid <= fetch;
        end
    end

    // word and its address, qualified by the valid strobe
    always_ff @(posedge i_clock) begin
        if (fetch) begin
            o_instruction    <= i_instruction;
            o_instruction_pc <= pc;
        end
    end

    assign o_read_address = pc;

endmodule

// ==== design/instruction_fetch.sv ====
`timescale 1ns/1ps

module instruction_fetch
#(
    parameter  int N_INSTRUCTIONS = 64,
    localparam int NB_ADDRESS     = $clog2(4 * N_INSTRUCTIONS)
)
(
    input  logic                                 i_clock,
    input  logic                                 i_reset,
    input  logic                                 i_load_valid,
    input  logic [fetch_pkg::NB_BYTE-1:0]        i_load_byte,
    input  logic                                 i_mode_write,
    input  logic                                 i_mode_step,
    input  logic                                 i_start,
    input  logic                                 i_step,
    output logic [fetch_pkg::NB_INSTRUCTION-1:0] o_instruction,
    output logic [NB_ADDRESS-1:0]                o_instruction_pc,
    output logic                                 o_instruction_valid,
    output logic                                 o_running,
    output logic                                 o_halted
);
    import fetch_pkg::*;

    // control to memory and pc
    logic                      write_enable;
    logic                      restart;
    logic                      advance;
    // pc back to control
    logic                      stop;
    // memory read side
    logic [NB_ADDRESS-1:0]     read_address;
    logic [NB_INSTRUCTION-1:0] read_instruction;
    logic                      is_program_end;

    // ---------------------------------------------------
    // byte loaded program store
    // ---------------------------------------------------
    instruction_memory #(
        .N_INSTRUCTIONS (N_INSTRUCTIONS),
        .NB_ADDRESS     (NB_ADDRESS)
    ) u_instruction_memory (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_write_enable     (write_enable),
        .i_write_data       (i_load_byte),
        .i_read_address     (read_address),
        .o_read_instruction (read_instruction),
        .o_is_program_end   (is_program_end)
    );

    // mode register and run / halt state
    fetch_control u_fetch_control (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_load_valid     (i_load_valid),
        .i_mode_write     (i_mode_write),
        .i_mode_step      (i_mode_step),
        .i_start          (i_start),
        .i_step           (i_step),
        .i_stop           (stop),
        .i_is_program_end (is_program_end),
        .o_write_enable   (write_enable),
        .o_restart        (restart),
        .o_advance        (advance),
        .o_running        (o_running),
        .o_halted         (o_halted)
    );

    // ---------------------------------------------------
    // pc, next pc and fetched word output
    // ---------------------------------------------------
    program_counter #(
        .NB_ADDRESS (NB_ADDRESS)
    ) u_program_counter (
        .i_clock             (i_clock),
        .i_reset             (i_reset),
        .i_restart           (restart),
        .i_advance           (advance),
        .i_is_program_end    (is_program_end),
        .i_instruction       (read_instruction),
        .o_read_address      (read_address),
        .o_stop              (stop),
        .o_instruction       (o_instruction),
        .o_instruction_pc    (o_instruction_pc),
        .o_instruction_valid (o_instruction_valid)
    );

endmodule

// ==== test/instruction_fetch_props.sv ====
`timescale 1ns/1ps

module instruction_fetch_props (
    input logic       i_clock,
    input logic       i_reset,
    input logic       i_mode_write,
    input logic       i_mode_step,
    input logic       i_start,
    input logic [1:0] i_pc_low,
    input logic       i_instruction_valid,
    input logic       i_running,
    input logic       i_halted
);

    // run mode as seen from the host pins
    logic step_mode;
    // read by the testbench at the end of the run
    int   failure_count = 0;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            step_mode <= 1'b0;
        end else if (i_mode_write && !i_running) begin
            step_mode <= i_mode_step;
        end
    end

    // --------------------------------------------------
    // output protocol
    // --------------------------------------------------
    valid_not_halted: assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_instruction_valid && i_halted))
        else begin failure_count++; $error("valid output while halted"); end

    pc_word_aligned: assert property (@(posedge i_clock) disable iff (i_reset)
        i_instruction_valid |-> (i_pc_low == 2'b00))
        else begin failure_count++; $error("instruction pc not word aligned"); end

    running_not_halted: assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_running && i_halted))
        else begin failure_count++; $error("running and halted both high"); end

    // continuous mode only, step mode waits for a step pulse
    start_quiet_cycle: assert property (@(posedge i_clock) disable iff (i_reset)
        (i_start && !i_running && !step_mode) |=> !i_instruction_valid)
        else begin failure_count++; $error("valid output one cycle after start"); end

    start_first_valid: assert property (@(posedge i_clock) disable iff (i_reset)
        (i_start && !i_running && !step_mode) |-> ##2 i_instruction_valid)
        else begin failure_count++; $error("no valid output two cycles after start"); end

endmodule

// ==== test/tb_instruction_fetch.sv ====
`timescale 1ns/1ps

module tb_instruction_fetch;
    import fetch_pkg::*;

    localparam int CLOCK_PERIOD = 100;
    localparam int RESET_CYCLES = 3;
    localparam int N_TESTS      = 6;
    // words loaded by all tests together
    localparam int LOADED_WORDS = 2 + 11 + 7 + 6 + 6 + 11;
    localparam int RUN_CYCLES   = 60;
    localparam int CYCLE_LIMIT  = N_TESTS * RESET_CYCLES + 4 * LOADED_WORDS +
                                  N_TESTS * RUN_CYCLES + 200;
    localparam logic [31:0] HALT_WORD = {OP_HALT, 26'd0};

    logic        clock = 1'b0;
    logic        reset;
    logic        load_valid;
    logic [7:0]  load_byte;
    logic        mode_write;
    logic        mode_step;
    logic        start;
    logic        step;
    logic [31:0] instruction;
    logic [7:0]  instruction_pc;
    logic        instruction_valid;
    logic        running;
    logic        halted;

    logic [31:0] program_words [$];
    logic [7:0]  expected_pc [$];
    logic [31:0] expected_word [$];
    logic [15:0] lfsr_state = 16'd50104;
    string       current_test = "reset";
    int          value_errors = 0;
    int          protocol_errors = 0;
    int          cycle_count = 0;

    instruction_fetch #(.N_INSTRUCTIONS(64)) DUT (
        .i_clock (clock), .i_reset (reset),
        .i_load_valid (load_valid), .i_load_byte (load_byte),
        .i_mode_write (mode_write), .i_mode_step (mode_step),
        .i_start (start), .i_step (step),
        .o_instruction (instruction), .o_instruction_pc (instruction_pc),
        .o_instruction_valid (instruction_valid),
        .o_running (running), .o_halted (halted)
    );

    bind instruction_fetch instruction_fetch_props u_props (
        .i_clock (i_clock), .i_reset (i_reset),
        .i_mode_write (i_mode_write), .i_mode_step (i_mode_step),
        .i_start (i_start), .i_pc_low (o_instruction_pc[1:0]),
        .i_instruction_valid (o_instruction_valid),
        .i_running (o_running), .i_halted (o_halted)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // run limit
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // stimulus helpers
    // --------------------------------------------------
    // galois lfsr, one step per bit
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
        end
        return value;
    endfunction

    // opcode 0, never a jump, branch or halt
    function automatic logic [31:0] filler_word();
        logic [31:0] bits;
        bits = random_bits(26);
        return {6'd0, bits[25:0]};
    endfunction

    function automatic logic [31:0] make_jump(input logic [25:0] target);
        instruction_t word;
        word.j_view.opcode = OP_JUMP;
        word.j_view.target = target;
        return word;
    endfunction

    function automatic logic [31:0] make_beq(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [15:0] offset);
        instruction_t word;
        word.i_view.opcode    = OP_BRANCH_EQ;
        word.i_view.rs        = rs;
        word.i_view.rt        = rt;
        word.i_view.immediate = offset;
        return word;
    endfunction

    // all tasks start and end 1 ns after a rising edge
    task automatic reset_dut();
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1 reset = 1'b0;
    endtask

    // big endian, top byte first
    task automatic load_program();
        for (int w = 0; w < program_words.size(); w++) begin
            for (int b = 3; b >= 0; b--) begin
                load_valid = 1'b1;
                load_byte  = program_words[w][8*b +: 8];
                @(posedge clock);
                #1;
            end
        end
        load_valid = 1'b0;
    endtask

    // reference model of the fetch order
    task automatic build_expected();
        instruction_t word;
        logic [7:0]   pc;
        logic         done;
        expected_pc.delete();
        expected_word.delete();
        pc   = '0;
        done = 1'b0;
        while (!done && int'(pc) < 4 * program_words.size() && pc != 8'd252) begin
            word = program_words[pc >> 2];
            expected_pc.push_back(pc);
            expected_word.push_back(word);
            if (word.i_view.opcode == OP_HALT) begin
                done = 1'b1;
            end else if (word.j_view.opcode == OP_JUMP) begin
                pc = {word.j_view.target[5:0], 2'b00};
            end else if (word.i_view.opcode == OP_BRANCH_EQ &&
                         word.i_view.rs == word.i_view.rt) begin
                pc = pc + 8'd4 + {word.i_view.immediate[5:0], 2'b00};
            end else begin
                pc = pc + 8'd4;
            end
        end
    endtask

    task automatic start_run();
        start = 1'b1;
        @(posedge clock);
        #1 start = 1'b0;
        assert (running) else begin
            value_errors++;
            $display("ERROR %s: o_running expected 1 actual %0d", current_test, running);
        end
    endtask

    // halt, a few quiet cycles, then nothing left to deliver
    task automatic wait_for_halt();
        while (!halted) begin
            @(posedge clock);
            #1;
        end
        repeat (4) @(posedge clock);
        #1;
        assert (expected_pc.size() == 0) else begin
            protocol_errors++;
            $display("%s: %0d expected words were never delivered",
                     current_test, expected_pc.size());
        end
        assert (!running) else begin
            value_errors++;
            $display("ERROR %s: o_running expected 0 actual %0d", current_test, running);
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            assert (!running) else begin
                value_errors++;
                $display("ERROR %s: o_running expected 0 actual %0d", current_test, running);
            end
            assert (!halted) else begin
                value_errors++;
                $display("ERROR %s: o_halted expected 0 actual %0d", current_test, halted);
            end
            @(posedge clock);
            #1;
        end
    endtask

    // step sampled on one edge, word fetched on the next
    task automatic step_once();
        int gap;
        gap = int'(random_bits(2));
        repeat (gap) @(posedge clock);
        #1 step = 1'b1;
        @(posedge clock);
        #1 step = 1'b0;
        @(negedge clock);
        assert (!instruction_valid) else begin
            value_errors++;
            $display("ERROR %s: valid one cycle after step expected 0 actual 1", current_test);
        end
        @(negedge clock);
        assert (instruction_valid) else begin
            value_errors++;
            $display("ERROR %s: valid two cycles after step expected 1 actual 0", current_test);
        end
        @(posedge clock);
        #1;
    endtask

    task automatic run_program();
        load_program();
        build_expected();
        start_run();
        wait_for_halt();
    endtask

    // --------------------------------------------------
    // output monitor
    // --------------------------------------------------
    always @(negedge clock) begin
        if (!reset && instruction_valid) begin
            if (expected_pc.size() == 0) begin
                protocol_errors++;
                $display("%s: extra valid output at pc %0d", current_test, instruction_pc);
            end else begin
                assert (instruction_pc == expected_pc[0]) else begin
                    value_errors++;
                    $display("ERROR %s: pc expected %h actual %h",
                             current_test, expected_pc[0], instruction_pc);
                end
                assert (instruction == expected_word[0]) else begin
                    value_errors++;
                    $display("ERROR %s: word expected %h actual %h",
                             current_test, expected_word[0], instruction);
                end
                expected_pc.delete(0);
                expected_word.delete(0);
            end
        end
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        reset      = 1'b1;
        load_valid = 1'b0;
        load_byte  = '0;
        mode_write = 1'b0;
        mode_step  = 1'b0;
        start      = 1'b0;
        step       = 1'b0;

        // loaded but never started
        reset_dut();
        check_idle(3);
        program_words = '{filler_word(), HALT_WORD};
        load_program();
        check_idle(5);

        current_test = "continuous";
        reset_dut();
        program_words.delete();
        repeat (10) program_words.push_back(filler_word());
        program_words.push_back(HALT_WORD);
        run_program();

        // 0 -> 4 jump -> 20 beq not taken -> 24 beq back -> 12 halt
        current_test = "control_flow";
        reset_dut();
        program_words = '{filler_word(), make_jump(26'd5), filler_word(), HALT_WORD,
                          filler_word(), make_beq(5'd1, 5'd2, 16'd3),
                          make_beq(5'd3, 5'd3, -16'sd4)};
        run_program();

        current_test = "program_end";
        reset_dut();
        program_words.delete();
        repeat (6) program_words.push_back(filler_word());
        run_program();

        current_test = "step_mode";
        reset_dut();
        mode_write = 1'b1;
        mode_step  = 1'b1;
        @(posedge clock);
        #1 mode_write = 1'b0;
        program_words.delete();
        repeat (5) program_words.push_back(filler_word());
        program_words.push_back(HALT_WORD);
        load_program();
        build_expected();
        start_run();
        repeat (expected_pc.size()) step_once();
        wait_for_halt();

        // no halt word, so a landed load would add a word
        current_test = "load_gating";
        reset_dut();
        program_words.delete();
        repeat (11) program_words.push_back(filler_word());
        load_program();
        build_expected();
        start_run();
        repeat (6) begin
            load_valid = 1'b1;
            load_byte  = 8'(random_bits(8));
            @(posedge clock);
            #1;
        end
        load_valid = 1'b0;
        wait_for_halt();
        build_expected();
        start_run();
        wait_for_halt();

        $display("errors: %0d value, %0d protocol, %0d assertion",
                 value_errors, protocol_errors, DUT.u_props.failure_count);
        if (value_errors == 0 && protocol_errors == 0 && DUT.u_props.failure_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== instruction_fetch.f ====
design/fetch_pkg.sv
design/instruction_memory.sv
design/fetch_control.sv
design/program_counter.sv
design/instruction_fetch.sv
test/instruction_fetch_props.sv
test/tb_instruction_fetch.sv

// ==== run.sh ====
#!/bin/sh
# build and run the instruction fetch testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert \
    --top-module tb_instruction_fetch \
    -f instruction_fetch.f \
    -o sim_instruction_fetch
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

# keep running past the first assertion error so the summary prints
output=$(./obj_dir/sim_instruction_fetch +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
